// File: dv/mem_subsys_model.sv
// Reference model for the memory subsystem testbench
// Shadow SRAM, LED value and per-port queues of expected responses

module mem_subsys_model #(
  parameter int unsigned        MemSize  = 4096,
  parameter soc_mem_pkg::addr_t MemStart = 32'h0000_0000,
  parameter soc_mem_pkg::addr_t LedAddr  = 32'h0001_0000
);

  timeunit 1ns;
  timeprecision 100ps;

  import soc_mem_pkg::*;

  typedef struct packed {
    logic [31:0] due;
    data_t       rdata;
    logic        err;
    logic [3:0]  led;
  } exp_rsp_t;

  data_t      shadow [MemSize/4];
  logic [3:0] led_val = 4'h0;
  exp_rsp_t   q_instr [$];
  exp_rsp_t   q_data [$];

  // Called once per granted request, in grant order
  function automatic void record_request(input bit is_data, input mem_req_t req,
                                         input logic [31:0] due);
    exp_rsp_t    e;
    int unsigned idx;
    bit          in_ram;
    bit          is_led;
    in_ram = ((req.addr & ~addr_t'(MemSize - 1)) == MemStart);
    is_led = (req.addr[31:2] == LedAddr[31:2]);
    idx    = (req.addr - MemStart) >> 2;
    e      = '0;
    e.due  = due;
    if (in_ram) begin
      if (req.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req.be[b]) begin
            shadow[idx][8*b +: 8] = req.wdata[8*b +: 8];
          end
        end
      end else begin
        e.rdata = shadow[idx];
      end
    end else if (is_led) begin
      if (req.we && req.be[0]) begin
        led_val = req.wdata[3:0];
      end else if (!req.we) begin
        e.rdata = {28'h0, led_val};
      end
    end else begin
      // Unmapped, no side effect
      e.err = 1'b1;
    end
    e.led = led_val;
    if (is_data) begin
      q_data.push_back(e);
    end else begin
      q_instr.push_back(e);
    end
  endfunction

  function automatic bit pop_expected(input bit is_data, output logic [31:0] due,
                                      output data_t rdata, output logic err,
                                      output logic [3:0] led);
    exp_rsp_t e;
    if (is_data ? (q_data.size() == 0) : (q_instr.size() == 0)) begin
      return 1'b0;
    end
    e     = is_data ? q_data.pop_front() : q_instr.pop_front();
    due   = e.due;
    rdata = e.rdata;
    err   = e.err;
    led   = e.led;
    return 1'b1;
  endfunction

  // All ones when nothing is pending
  function automatic logic [31:0] front_due(input bit is_data);
    if (is_data) begin
      return (q_data.size() != 0) ? q_data[0].due : '1;
    end
    return (q_instr.size() != 0) ? q_instr[0].due : '1;
  endfunction

  function automatic int unsigned pending(input bit is_data);
    return is_data ? q_data.size() : q_instr.size();
  endfunction

endmodule

// File: dv/mem_subsys_tb.sv
// Testbench for the memory subsystem
// Random fetch and data traffic checked against a reference model

module mem_subsys_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import soc_mem_pkg::*;

  localparam int unsigned MemSize        = 4096;
  localparam addr_t       MemStart       = 32'h0000_0000;
  localparam addr_t       LedAddr        = 32'h0001_0000;
  localparam int unsigned RamWords       = 16;
  localparam int unsigned NumInstr       = 300;
  localparam int unsigned NumData        = 300;
  localparam int unsigned WatchdogCycles = (NumInstr + NumData) * 20 + 100;

  logic       clk_sys = 1'b0;
  logic       rst_sys_n;
  logic       instr_req_i;
  addr_t      instr_addr_i;
  logic       instr_gnt_o;
  logic       instr_rvalid_o;
  data_t      instr_rdata_o;
  logic       instr_err_o;
  logic       data_req_i;
  logic       data_we_i;
  be_t        data_be_i;
  addr_t      data_addr_i;
  data_t      data_wdata_i;
  logic       data_gnt_o;
  logic       data_rvalid_o;
  data_t      data_rdata_o;
  logic       data_err_o;
  logic [3:0] led_o;

  logic [31:0] rng_state;
  logic [31:0] cycle;
  mem_req_t    instr_cur;
  mem_req_t    data_cur;
  int unsigned instr_issued;
  int unsigned data_issued;
  int unsigned data_grants;
  int unsigned contended;
  bit          instr_gnt_seen;
  bit          data_gnt_seen;

  mem_subsys_top #(
    .MemSize (MemSize),
    .MemStart(MemStart),
    .LedAddr (LedAddr)
  ) u_dut (
    .clk_sys       (clk_sys),
    .rst_sys_n     (rst_sys_n),
    .instr_req_i   (instr_req_i),
    .instr_addr_i  (instr_addr_i),
    .instr_gnt_o   (instr_gnt_o),
    .instr_rvalid_o(instr_rvalid_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_err_o   (instr_err_o),
    .data_req_i    (data_req_i),
    .data_we_i     (data_we_i),
    .data_be_i     (data_be_i),
    .data_addr_i   (data_addr_i),
    .data_wdata_i  (data_wdata_i),
    .data_gnt_o    (data_gnt_o),
    .data_rvalid_o (data_rvalid_o),
    .data_rdata_o  (data_rdata_o),
    .data_err_o    (data_err_o),
    .led_o         (led_o)
  );

  mem_subsys_model #(
    .MemSize (MemSize),
    .MemStart(MemStart),
    .LedAddr (LedAddr)
  ) u_model ();

  always #2 clk_sys = ~clk_sys;

  task automatic stop_failed();
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("[ERROR] %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
    stop_failed();
  endtask

  task automatic report_fault(input string reason);
    $display("[ERROR] %0d ns: %s", $time, reason);
    stop_failed();
  endtask

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Mostly a 16-word RAM range, some LED and unmapped addresses
  function automatic addr_t pick_addr(input logic [31:0] r);
    if (r[15:12] < 4'd11) begin
      return MemStart + addr_t'({r[7:4], 2'b00});
    end else if (r[15:12] < 4'd13) begin
      return LedAddr | addr_t'(r[9:8]);
    end
    return 32'h0002_0000 | addr_t'({r[11:4], 2'b00});
  endfunction

  task automatic drive_instr();
    logic [31:0] r;
    r = next_rand();
    if (!instr_req_i || instr_gnt_seen) begin
      // Fetches wait until the RAM range holds known data
      if (instr_issued < NumInstr && data_grants >= RamWords && r[0]) begin
        instr_cur      = '0;
        instr_cur.addr = pick_addr(next_rand());
        instr_issued++;
        instr_req_i  <= 1'b1;
        instr_addr_i <= instr_cur.addr;
      end else begin
        instr_req_i <= 1'b0;
      end
    end
  endtask

  task automatic drive_data();
    logic [31:0] r;
    bit          start;
    r     = next_rand();
    start = 1'b0;
    if (!data_req_i || data_gnt_seen) begin
      data_cur = '0;
      if (data_issued < RamWords) begin
        data_cur.addr  = MemStart + addr_t'(data_issued * 4);
        data_cur.we    = 1'b1;
        data_cur.be    = '1;
        data_cur.wdata = next_rand();
        start = 1'b1;
      end else if (data_issued < NumData && r[1]) begin
        data_cur.addr  = pick_addr(r);
        data_cur.we    = r[20];
        data_cur.be    = r[24:21];
        data_cur.wdata = next_rand();
        start = 1'b1;
      end
      if (start) begin
        data_issued++;
        data_req_i   <= 1'b1;
        data_we_i    <= data_cur.we;
        data_be_i    <= data_cur.be;
        data_addr_i  <= data_cur.addr;
        data_wdata_i <= data_cur.wdata;
      end else begin
        data_req_i <= 1'b0;
      end
    end
  endtask

  task automatic check_port(input bit is_data, input string prefix, input logic rvalid,
                            input data_t rdata, input logic err);
    logic [31:0] due;
    data_t       exp_rdata;
    logic        exp_err;
    logic [3:0]  exp_led;
    bit          have;
    if (rvalid === 1'b1) begin
      have = u_model.pop_expected(is_data, due, exp_rdata, exp_err, exp_led);
      assert (have)
        else report_fault($sformatf("%s rvalid with no pending request", prefix));
      assert (due == cycle)
        else report_fault($sformatf("%s response in cycle %0d, expected in cycle %0d",
                                    prefix, cycle, due));
      assert (rdata === exp_rdata)
        else report_value($sformatf("%s_rdata_o", prefix), rdata, exp_rdata);
      assert (err === exp_err)
        else report_value($sformatf("%s_err_o", prefix), {31'h0, err}, {31'h0, exp_err});
      assert (led_o === exp_led)
        else report_value("led_o", {28'h0, led_o}, {28'h0, exp_led});
    end else begin
      assert (rvalid === 1'b0)
        else report_fault($sformatf("%s rvalid is unknown", prefix));
      assert (err === 1'b0)
        else report_fault($sformatf("%s err is high without rvalid", prefix));
      assert (u_model.front_due(is_data) > cycle)
        else report_fault($sformatf("%s response missing in cycle %0d", prefix, cycle));
    end
  endtask

  // Outputs are sampled half a cycle away from the driving edge
  always @(negedge clk_sys) begin
    if (rst_sys_n) begin
      cycle = cycle + 1;
      assert (instr_gnt_o === instr_req_i)
        else report_value("instr_gnt_o", {31'h0, instr_gnt_o}, {31'h0, instr_req_i});
      assert (data_gnt_o === (data_req_i & ~instr_req_i))
        else report_value("data_gnt_o", {31'h0, data_gnt_o},
                          {31'h0, data_req_i & ~instr_req_i});
      if (instr_req_i && data_req_i) begin
        contended++;
      end
      check_port(1'b0, "instr", instr_rvalid_o, instr_rdata_o, instr_err_o);
      check_port(1'b1, "data", data_rvalid_o, data_rdata_o, data_err_o);
      if (instr_gnt_o) begin
        u_model.record_request(1'b0, instr_cur, cycle + 2);
      end
      if (data_gnt_o) begin
        u_model.record_request(1'b1, data_cur, cycle + 2);
        data_grants++;
      end
      instr_gnt_seen = instr_gnt_o;
      data_gnt_seen  = data_gnt_o;
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_sys);
    report_fault("watchdog expired before all requests completed");
  end

  initial begin
    rng_state      = 32'he73c;
    cycle          = '0;
    instr_cur      = '0;
    data_cur       = '0;
    instr_issued   = 0;
    data_issued    = 0;
    data_grants    = 0;
    contended      = 0;
    instr_gnt_seen = 1'b0;
    data_gnt_seen  = 1'b0;
    rst_sys_n      = 1'b0;
    instr_req_i    = 1'b0;
    instr_addr_i   = '0;
    data_req_i     = 1'b0;
    data_we_i      = 1'b0;
    data_be_i      = '0;
    data_addr_i    = '0;
    data_wdata_i   = '0;
    repeat (5) @(posedge clk_sys);
    rst_sys_n <= 1'b1;

    while (instr_issued < NumInstr || data_issued < NumData || instr_req_i || data_req_i) begin
      @(posedge clk_sys);
      drive_instr();
      drive_data();
      // Request lines are read back once their new values have settled
      @(negedge clk_sys);
    end
    // Last responses are two cycles behind the last grant
    repeat (3) @(negedge clk_sys);

    if (u_model.pending(1'b0) == 0 && u_model.pending(1'b1) == 0 && contended > 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      report_fault($sformatf(
          "end of run with %0d fetch and %0d data pending, %0d contended cycles",
          u_model.pending(1'b0), u_model.pending(1'b1), contended));
    end
  end

endmodule

// File: filelist.f
source/soc_mem_pkg.sv
source/mem_arbiter.sv
source/sram_1p.sv
source/resp_router.sv
source/led_reg.sv
source/mem_subsys_top.sv
dv/mem_subsys_model.sv
dv/mem_subsys_tb.sv

// File: source/led_reg.sv
// Memory-mapped LED register
// Low nibble of byte 0 is stored and driven on the LED pins

module led_reg (
  input  logic               clk_sys,
  input  logic               rst_sys_n,
  input  logic               we_i,
  input  soc_mem_pkg::be_t   be_i,
  input  soc_mem_pkg::data_t wdata_i,
  output logic [3:0]         led_o
);

  logic [3:0] led_q;

  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      led_q <= 4'h0;
    end else if (we_i && be_i[0]) begin
      // Other lanes have no storage
      led_q <= wdata_i[3:0];
    end
  end

  assign led_o = led_q;

endmodule

// File: source/mem_arbiter.sv
// Request arbiter, first pipeline stage
// Instruction port wins, target is decoded and the pick is registered

module mem_arbiter #(
  parameter int unsigned        MemSize  = 4096,
  parameter soc_mem_pkg::addr_t MemStart = 32'h0000_0000,
  parameter soc_mem_pkg::addr_t LedAddr  = 32'h0001_0000
) (
  input  logic                  clk_sys,
  input  logic                  rst_sys_n,

  input  logic                  instr_req_i,
  input  soc_mem_pkg::addr_t    instr_addr_i,
  output logic                  instr_gnt_o,

  input  logic                  data_req_i,
  input  logic                  data_we_i,
  input  soc_mem_pkg::be_t      data_be_i,
  input  soc_mem_pkg::addr_t    data_addr_i,
  input  soc_mem_pkg::data_t    data_wdata_i,
  output logic                  data_gnt_o,

  output logic                  req_valid_o,
  output soc_mem_pkg::mem_req_t req_o
);

  import soc_mem_pkg::*;

  localparam addr_t MemMask = addr_t'(MemSize - 1);

  mem_req_t req_d;
  mem_req_t req_q;
  logic     req_valid_q;
  logic     any_req;

  function automatic target_e decode_target(input addr_t addr);
    if ((addr & ~MemMask) == MemStart) begin
      return TGT_RAM;
    end else if ({addr[31:2], 2'b00} == LedAddr) begin
      return TGT_LED;
    end
    return TGT_NONE;
  endfunction

  // Fixed priority, fetch first
  assign instr_gnt_o = instr_req_i;
  assign data_gnt_o  = data_req_i & ~instr_req_i;
  assign any_req     = instr_req_i | data_req_i;

  always_comb begin
    req_d = '0;
    if (instr_req_i) begin
      req_d.addr = instr_addr_i;
      req_d.we   = 1'b0;
      req_d.be   = '1;
      req_d.port = PORT_INSTR;
    end else begin
      req_d.addr  = data_addr_i;
      req_d.we    = data_we_i;
      req_d.be    = data_be_i;
      req_d.wdata = data_wdata_i;
      req_d.port  = PORT_DATA;
    end
    req_d.target = decode_target(req_d.addr);
  end

  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= any_req;
    end
  end

  // Payload only, qualified by req_valid_q
  always_ff @(posedge clk_sys) begin
    if (any_req) begin
      req_q <= req_d;
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_o       = req_q;

  // One grant per cycle
  a_gnt_onehot: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    !(instr_gnt_o && data_gnt_o));

  a_gnt_needs_req: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    (instr_gnt_o |-> instr_req_i) and (data_gnt_o |-> data_req_i));

  // A data grant shows up in stage 1 tagged as a data access
  a_data_gnt_stage1: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    data_gnt_o |=> (req_valid_o && req_o.port == PORT_DATA));

endmodule

// File: source/mem_subsys_top.sv
// Memory subsystem top level
// Arbiter, SRAM, response router and LED register for two requesters

module mem_subsys_top #(
  parameter int unsigned        MemSize  = 4096,
  parameter soc_mem_pkg::addr_t MemStart = 32'h0000_0000,
  parameter soc_mem_pkg::addr_t LedAddr  = 32'h0001_0000
) (
  input  logic               clk_sys,
  input  logic               rst_sys_n,

  // Instruction fetch port
  input  logic               instr_req_i,
  input  soc_mem_pkg::addr_t instr_addr_i,
  output logic               instr_gnt_o,
  output logic               instr_rvalid_o,
  output soc_mem_pkg::data_t instr_rdata_o,
  output logic               instr_err_o,

  // Data port
  input  logic               data_req_i,
  input  logic               data_we_i,
  input  soc_mem_pkg::be_t   data_be_i,
  input  soc_mem_pkg::addr_t data_addr_i,
  input  soc_mem_pkg::data_t data_wdata_i,
  output logic               data_gnt_o,
  output logic               data_rvalid_o,
  output soc_mem_pkg::data_t data_rdata_o,
  output logic               data_err_o,

  output logic [3:0]         led_o
);

  import soc_mem_pkg::*;

  logic     arb_valid;
  mem_req_t arb_req;
  data_t    ram_rdata;
  logic     led_we;
  mem_rsp_t rsp;

  mem_arbiter #(
    .MemSize (MemSize),
    .MemStart(MemStart),
    .LedAddr (LedAddr)
  ) u_arbiter (
    .clk_sys     (clk_sys),
    .rst_sys_n   (rst_sys_n),
    .instr_req_i (instr_req_i),
    .instr_addr_i(instr_addr_i),
    .instr_gnt_o (instr_gnt_o),
    .data_req_i  (data_req_i),
    .data_we_i   (data_we_i),
    .data_be_i   (data_be_i),
    .data_addr_i (data_addr_i),
    .data_wdata_i(data_wdata_i),
    .data_gnt_o  (data_gnt_o),
    .req_valid_o (arb_valid),
    .req_o       (arb_req)
  );

  sram_1p #(
    .MemSize(MemSize)
  ) u_sram (
    .clk_sys    (clk_sys),
    .rst_sys_n  (rst_sys_n),
    .req_valid_i(arb_valid),
    .req_i      (arb_req),
    .rdata_o    (ram_rdata)
  );

  resp_router u_router (
    .clk_sys    (clk_sys),
    .rst_sys_n  (rst_sys_n),
    .req_valid_i(arb_valid),
    .req_i      (arb_req),
    .ram_rdata_i(ram_rdata),
    .led_i      (led_o),
    .led_we_o   (led_we),
    .rsp_o      (rsp)
  );

  // Write data and strobes come straight from stage 1
  led_reg u_led (
    .clk_sys  (clk_sys),
    .rst_sys_n(rst_sys_n),
    .we_i     (led_we),
    .be_i     (arb_req.be),
    .wdata_i  (arb_req.wdata),
    .led_o    (led_o)
  );

  // Split the shared response by port tag
  assign instr_rvalid_o = rsp.valid && (rsp.port == PORT_INSTR);
  assign data_rvalid_o  = rsp.valid && (rsp.port == PORT_DATA);
  assign instr_rdata_o  = rsp.rdata;
  assign data_rdata_o   = rsp.rdata;
  assign instr_err_o    = rsp.err && (rsp.port == PORT_INSTR);
  assign data_err_o     = rsp.err && (rsp.port == PORT_DATA);

  // Fixed two-cycle latency from grant to response across all stages
  a_instr_latency: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    instr_gnt_o |-> ##2 instr_rvalid_o);

  a_data_latency: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    data_gnt_o |-> ##2 data_rvalid_o);

endmodule

// File: source/resp_router.sv
// Response router, third pipeline stage
// Tags ride beside the SRAM, then read data or error returns per port

module resp_router (
  input  logic                  clk_sys,
  input  logic                  rst_sys_n,
  input  logic                  req_valid_i,
  input  soc_mem_pkg::mem_req_t req_i,
  input  soc_mem_pkg::data_t    ram_rdata_i,
  input  logic [3:0]            led_i,
  output logic                  led_we_o,
  output soc_mem_pkg::mem_rsp_t rsp_o
);

  import soc_mem_pkg::*;

  logic       rsp_valid_q;
  port_e      port_q;
  target_e    tgt_q;
  logic       we_q;
  logic [3:0] led_q;

  // Only the data port can write
  assign led_we_o = req_valid_i && req_i.we && (req_i.port == PORT_DATA) &&
                    (req_i.target == TGT_LED);

  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  // Tag travels alongside the SRAM read
  always_ff @(posedge clk_sys) begin
    if (req_valid_i) begin
      port_q <= req_i.port;
      tgt_q  <= req_i.target;
      we_q   <= req_i.we;
      led_q  <= led_i;
    end
  end

  always_comb begin
    rsp_o.valid = rsp_valid_q;
    rsp_o.port  = port_q;
    rsp_o.err   = rsp_valid_q && (tgt_q == TGT_NONE);
    rsp_o.rdata = '0;
    if (!we_q) begin
      case (tgt_q)
        TGT_RAM: rsp_o.rdata = ram_rdata_i;
        TGT_LED: rsp_o.rdata = {28'h0, led_q};
        default: rsp_o.rdata = '0;
      endcase
    end
  end

endmodule

// File: source/soc_mem_pkg.sv
// Memory subsystem shared types
// Widths, port and decode enums, and the request/response structs

package soc_mem_pkg;

  // Bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // Which requester issued an access
  typedef enum logic {
    PORT_INSTR = 1'b0,
    PORT_DATA  = 1'b1
  } port_e;

  // Address decode result
  typedef enum logic [1:0] {
    TGT_RAM  = 2'd0,
    TGT_LED  = 2'd1,
    TGT_NONE = 2'd2
  } target_e;

  // Stage-1 request, 72 bits
  typedef struct packed {
    addr_t   addr;
    logic    we;
    be_t     be;
    data_t   wdata;
    port_e   port;
    target_e target;
  } mem_req_t;

  // Response towards the requesters, 35 bits
  typedef struct packed {
    logic  valid;
    port_e port;
    data_t rdata;
    logic  err;
  } mem_rsp_t;

endpackage

// File: source/sram_1p.sv
// Single-port word SRAM, second pipeline stage
// Byte-enabled writes, reads return one cycle after the access

module sram_1p #(
  parameter int unsigned MemSize = 4096
) (
  input  logic                  clk_sys,
  input  logic                  rst_sys_n,
  input  logic                  req_valid_i,
  input  soc_mem_pkg::mem_req_t req_i,
  output soc_mem_pkg::data_t    rdata_o
);

  import soc_mem_pkg::*;

  localparam int unsigned Depth    = MemSize / 4;
  localparam int unsigned IdxW     = $clog2(Depth);
  localparam int unsigned NumBytes = $bits(be_t);

  data_t           mem_q [Depth];
  data_t           rdata_q;
  logic [IdxW-1:0] word_idx;
  logic            access;

  // Byte offset dropped, window base ignored
  assign word_idx = req_i.addr[IdxW+1:2];
  assign access   = req_valid_i && (req_i.target == TGT_RAM);

  always_ff @(posedge clk_sys) begin
    if (access) begin
      if (req_i.we) begin
        for (int i = 0; i < NumBytes; i++) begin
          if (req_i.be[i]) begin
            mem_q[word_idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  assign rdata_o = rdata_q;

  a_idx_in_range: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    access |-> (int'(word_idx) < Depth));

endmodule
